//--- include/id_cfg.svh
`ifndef ID_CFG_SVH
`define ID_CFG_SVH

// Data path and PC width
`define ID_XLEN 32

// Register file geometry
`define ID_NUM_REGS 32
`define ID_REG_ADDR_W 5

// Low bits of the register fields in an uncompressed instruction
`define ID_RS1_LSB 15
`define ID_RS2_LSB 20
`define ID_RD_LSB 7

// Major opcode field, bits 6:0
`define ID_OPCODE_W 7

`endif

//--- rtl/id_pkg.sv
`default_nettype none

`include "id_cfg.svh"

package id_pkg;

  //////////////////////////////////////////////////
  // Major opcodes handled by the decode stage
  //////////////////////////////////////////////////
  typedef enum logic [`ID_OPCODE_W-1:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  // ALU operations seen by EX
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_XOR  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_AND  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_e;

  // Operand A source, zero only for LUI
  typedef enum logic [1:0] {
    OP_A_REG  = 2'd0,
    OP_A_PC   = 2'd1,
    OP_A_ZERO = 2'd2
  } op_a_sel_e;

  // Operand B source, PC increment is the link value of JAL
  typedef enum logic [1:0] {
    OP_B_REG    = 2'd0,
    OP_B_IMM    = 2'd1,
    OP_B_PCINCR = 2'd2
  } op_b_sel_e;

  // Immediate formats
  typedef enum logic [1:0] {
    IMM_I = 2'd0,
    IMM_S = 2'd1,
    IMM_U = 2'd2,
    IMM_J = 2'd3
  } imm_sel_e;

endpackage

`default_nettype wire

//--- rtl/id_decoder.sv
`default_nettype none

`include "id_cfg.svh"

module id_decoder
(
  input  logic [`ID_XLEN-1:0] instr_i,

  output id_pkg::alu_op_e     alu_op_o,
  output id_pkg::op_a_sel_e   op_a_sel_o,
  output id_pkg::op_b_sel_e   op_b_sel_o,
  output logic [`ID_XLEN-1:0] imm_o,
  output logic                rd_we_o,
  output logic                illegal_o
);

  id_pkg::opcode_e   opcode;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  id_pkg::imm_sel_e  imm_sel;

  logic [`ID_XLEN-1:0] imm_i_type;
  logic [`ID_XLEN-1:0] imm_s_type;
  logic [`ID_XLEN-1:0] imm_u_type;
  logic [`ID_XLEN-1:0] imm_j_type;

  // Shared funct3 map of OP and OP-IMM
  // alt selects sub / sra
  function automatic id_pkg::alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
    id_pkg::alu_op_e op;
    case (f3)
      3'b000:  op = alt ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
      3'b001:  op = id_pkg::ALU_SLL;
      3'b010:  op = id_pkg::ALU_SLT;
      3'b011:  op = id_pkg::ALU_SLTU;
      3'b100:  op = id_pkg::ALU_XOR;
      3'b101:  op = alt ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
      3'b110:  op = id_pkg::ALU_OR;
      default: op = id_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode = id_pkg::opcode_e'(instr_i[`ID_OPCODE_W-1:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  //////////////////////////////////////////////////
  // Immediate extraction
  //////////////////////////////////////////////////

  // Sign bit is always instr[31]
  assign imm_i_type = {{(`ID_XLEN-12){instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{(`ID_XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_u_type = {instr_i[31:12], 12'b0};
  assign imm_j_type = {{(`ID_XLEN-20){instr_i[31]}}, instr_i[19:12], instr_i[20],
                       instr_i[30:21], 1'b0};

  always_comb
  begin : imm_mux
    case (imm_sel)
      id_pkg::IMM_S: imm_o = imm_s_type;
      id_pkg::IMM_U: imm_o = imm_u_type;
      id_pkg::IMM_J: imm_o = imm_j_type;
      default:       imm_o = imm_i_type;
    endcase
  end

  //////////////////////////////////////////////////
  // Opcode decode
  //////////////////////////////////////////////////
  always_comb
  begin : decode
    // Defaults fit a plain register ALU op
    alu_op_o   = id_pkg::ALU_ADD;
    op_a_sel_o = id_pkg::OP_A_REG;
    op_b_sel_o = id_pkg::OP_B_REG;
    imm_sel    = id_pkg::IMM_I;
    rd_we_o    = 1'b1;
    illegal_o  = 1'b0;

    case (opcode)
      id_pkg::OPC_OP:
      begin
        alu_op_o = alu_from_funct3(funct3, funct7[5]);
        // Only sub and sra take the alternate funct7
        if (funct7 == 7'b0100000)
          illegal_o = (funct3 != 3'b000) && (funct3 != 3'b101);
        else
          illegal_o = (funct7 != 7'b0000000);
        rd_we_o = !illegal_o;
      end
      id_pkg::OPC_OP_IMM:
      begin
        op_b_sel_o = id_pkg::OP_B_IMM;
        alu_op_o   = alu_from_funct3(funct3, (funct3 == 3'b101) && funct7[5]);
        // Shift amounts carry funct7 in the immediate
        if (funct3 == 3'b001)
          illegal_o = (funct7 != 7'b0000000);
        else if (funct3 == 3'b101)
          illegal_o = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
        rd_we_o = !illegal_o;
      end
      id_pkg::OPC_LUI:
      begin
        op_a_sel_o = id_pkg::OP_A_ZERO;
        op_b_sel_o = id_pkg::OP_B_IMM;
        imm_sel    = id_pkg::IMM_U;
      end
      id_pkg::OPC_AUIPC:
      begin
        op_a_sel_o = id_pkg::OP_A_PC;
        op_b_sel_o = id_pkg::OP_B_IMM;
        imm_sel    = id_pkg::IMM_U;
      end
      id_pkg::OPC_LOAD:
      begin
        // Address = rs1 + I immediate; lb lh lw lbu lhu only
        op_b_sel_o = id_pkg::OP_B_IMM;
        illegal_o  = (funct3 == 3'b011) || (funct3 == 3'b110) || (funct3 == 3'b111);
        rd_we_o    = !illegal_o;
      end
      id_pkg::OPC_STORE:
      begin
        op_b_sel_o = id_pkg::OP_B_IMM;
        imm_sel    = id_pkg::IMM_S;
        rd_we_o    = 1'b0;
        illegal_o  = (funct3[2] == 1'b1) || (funct3 == 3'b011);
      end
      id_pkg::OPC_JAL:
      begin
        // Link value pc + 4, target is handled elsewhere
        op_a_sel_o = id_pkg::OP_A_PC;
        op_b_sel_o = id_pkg::OP_B_PCINCR;
        imm_sel    = id_pkg::IMM_J;
      end
      default:
      begin
        illegal_o = 1'b1;
        rd_we_o   = 1'b0;
      end
    endcase
  end

  // Checked after the decode settles in each time step
  illegal_no_write_a: assert final (!(illegal_o && rd_we_o))
    else $error("decoder flags illegal and requests an rd write");

endmodule

`default_nettype wire

//--- rtl/id_operand_fetch.sv
`default_nettype none

`include "id_cfg.svh"

module id_operand_fetch
(
  input  logic                      clk,
  input  logic                      rst_n,

  input  logic [`ID_XLEN-1:0]       instr_i,

  // Write-back port
  input  logic                      wb_we_i,
  input  logic [`ID_REG_ADDR_W-1:0] wb_waddr_i,
  input  logic [`ID_XLEN-1:0]       wb_wdata_i,

  // EX result port
  input  logic                      fw_we_i,
  input  logic [`ID_REG_ADDR_W-1:0] fw_waddr_i,
  input  logic [`ID_XLEN-1:0]       fw_wdata_i,

  output logic [`ID_XLEN-1:0]       rs1_data_o,
  output logic [`ID_XLEN-1:0]       rs2_data_o
);

  // x0 has no storage
  logic [`ID_XLEN-1:0] regs [1:`ID_NUM_REGS-1];

  logic [`ID_REG_ADDR_W-1:0] rs1_addr;
  logic [`ID_REG_ADDR_W-1:0] rs2_addr;

  // Forwarding priority EX, then WB, then storage
  function automatic logic [`ID_XLEN-1:0] fwd_operand(input logic [`ID_REG_ADDR_W-1:0] addr);
    logic [`ID_XLEN-1:0] data;
    if (addr == '0)
      data = '0;
    else if (fw_we_i && (fw_waddr_i == addr))
      data = fw_wdata_i;
    else if (wb_we_i && (wb_waddr_i == addr))
      data = wb_wdata_i;
    else
      data = regs[addr];
    return data;
  endfunction

  assign rs1_addr = instr_i[`ID_RS1_LSB +: `ID_REG_ADDR_W];
  assign rs2_addr = instr_i[`ID_RS2_LSB +: `ID_REG_ADDR_W];

  //////////////////////////////////////////////////
  // Register storage, two write ports
  //////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n)
  begin : reg_write
    if (!rst_n)
    begin
      for (int unsigned i = 1; i < `ID_NUM_REGS; i++)
        regs[i] <= '0;
    end
    else
    begin
      for (int unsigned i = 1; i < `ID_NUM_REGS; i++)
      begin
        // EX port wins on the same address
        if (fw_we_i && (fw_waddr_i == `ID_REG_ADDR_W'(i)))
          regs[i] <= fw_wdata_i;
        else if (wb_we_i && (wb_waddr_i == `ID_REG_ADDR_W'(i)))
          regs[i] <= wb_wdata_i;
      end
    end
  end

  // Read plus forwarding
  always_comb
  begin : operand_mux
    rs1_data_o = fwd_operand(rs1_addr);
    rs2_data_o = fwd_operand(rs2_addr);
  end

  // An EX port write always lands even on a WB collision
  fw_write_lands_a: assert property (@(posedge clk) disable iff (!rst_n)
    (fw_we_i && (fw_waddr_i != '0)) |=> (regs[$past(fw_waddr_i)] == $past(fw_wdata_i)))
    else $error("EX port write did not reach the register file");

endmodule

`default_nettype wire

//--- rtl/id_ex_pipe.sv
`default_nettype none

`include "id_cfg.svh"

module id_ex_pipe
(
  input  logic                      clk,
  input  logic                      rst_n,

  input  logic [`ID_XLEN-1:0]       instr_i,
  input  logic [`ID_XLEN-1:0]       pc_i,
  input  logic                      instr_valid_i,
  input  logic                      stall_ex_i,

  // From the decoder
  input  id_pkg::alu_op_e           alu_op_i,
  input  id_pkg::op_a_sel_e         op_a_sel_i,
  input  id_pkg::op_b_sel_e         op_b_sel_i,
  input  logic [`ID_XLEN-1:0]       imm_i,
  input  logic                      rd_we_i,
  input  logic                      illegal_i,

  // Forwarded source registers
  input  logic [`ID_XLEN-1:0]       rs1_data_i,
  input  logic [`ID_XLEN-1:0]       rs2_data_i,

  output logic                      ex_valid_o,
  output id_pkg::alu_op_e           ex_alu_op_o,
  output logic [`ID_XLEN-1:0]       ex_operand_a_o,
  output logic [`ID_XLEN-1:0]       ex_operand_b_o,
  output logic [`ID_XLEN-1:0]       ex_store_data_o,
  output logic [`ID_REG_ADDR_W-1:0] ex_rd_addr_o,
  output logic                      ex_regfile_we_o,
  output logic                      ex_illegal_o
);

  logic [`ID_XLEN-1:0] operand_a;
  logic [`ID_XLEN-1:0] operand_b;

  //////////////////////////////////////////////////
  // Operand selection
  //////////////////////////////////////////////////
  always_comb
  begin : operand_a_mux
    case (op_a_sel_i)
      id_pkg::OP_A_REG: operand_a = rs1_data_i;
      id_pkg::OP_A_PC:  operand_a = pc_i;
      default:          operand_a = '0;
    endcase
  end

  always_comb
  begin : operand_b_mux
    case (op_b_sel_i)
      id_pkg::OP_B_IMM:    operand_b = imm_i;
      // Link value, instructions are always 4 bytes here
      id_pkg::OP_B_PCINCR: operand_b = `ID_XLEN'(4);
      default:             operand_b = rs2_data_i;
    endcase
  end

  //////////////////////////////////////////////////
  // ID/EX register
  //////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n)
  begin : id_ex_regs
    if (!rst_n)
    begin
      ex_valid_o      <= 1'b0;
      ex_alu_op_o     <= id_pkg::ALU_ADD;
      ex_operand_a_o  <= '0;
      ex_operand_b_o  <= '0;
      ex_store_data_o <= '0;
      ex_rd_addr_o    <= '0;
      ex_regfile_we_o <= 1'b0;
      ex_illegal_o    <= 1'b0;
    end
    else if (!stall_ex_i)
    begin
      // Stall from EX holds every field
      ex_valid_o      <= instr_valid_i;
      ex_alu_op_o     <= alu_op_i;
      ex_operand_a_o  <= operand_a;
      ex_operand_b_o  <= operand_b;
      ex_store_data_o <= rs2_data_i;
      ex_rd_addr_o    <= instr_i[`ID_RD_LSB +: `ID_REG_ADDR_W];
      // Empty slot writes nothing and raises nothing
      ex_regfile_we_o <= rd_we_i && instr_valid_i;
      ex_illegal_o    <= illegal_i && instr_valid_i;
    end
  end

  // EX consumes valid every cycle, so it must be known
  ex_valid_known_a: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(ex_valid_o))
    else $error("ex_valid_o is unknown after reset");

endmodule

`default_nettype wire

//--- rtl/id_stage.sv
`default_nettype none

`include "id_cfg.svh"

module id_stage
(
  input  logic                      clk,
  input  logic                      rst_n,

  // From IF
  input  logic [`ID_XLEN-1:0]       instr_i,
  input  logic [`ID_XLEN-1:0]       pc_i,
  input  logic                      instr_valid_i,

  // Back-pressure from EX
  input  logic                      stall_ex_i,

  // Write-back port
  input  logic                      wb_we_i,
  input  logic [`ID_REG_ADDR_W-1:0] wb_waddr_i,
  input  logic [`ID_XLEN-1:0]       wb_wdata_i,

  // EX result port
  input  logic                      fw_we_i,
  input  logic [`ID_REG_ADDR_W-1:0] fw_waddr_i,
  input  logic [`ID_XLEN-1:0]       fw_wdata_i,

  // To EX
  output logic                      ex_valid_o,
  output id_pkg::alu_op_e           ex_alu_op_o,
  output logic [`ID_XLEN-1:0]       ex_operand_a_o,
  output logic [`ID_XLEN-1:0]       ex_operand_b_o,
  output logic [`ID_XLEN-1:0]       ex_store_data_o,
  output logic [`ID_REG_ADDR_W-1:0] ex_rd_addr_o,
  output logic                      ex_regfile_we_o,
  output logic                      ex_illegal_o
);

  // Decoder results
  id_pkg::alu_op_e     alu_op;
  id_pkg::op_a_sel_e   op_a_sel;
  id_pkg::op_b_sel_e   op_b_sel;
  logic [`ID_XLEN-1:0] imm;
  logic                rd_we;
  logic                illegal;

  // Forwarded operands
  logic [`ID_XLEN-1:0] rs1_data;
  logic [`ID_XLEN-1:0] rs2_data;

  //////////////////////////////////////////////////
  // Decode and operand fetch run side by side
  //////////////////////////////////////////////////
  id_decoder i_decoder (
    .instr_i    ( instr_i  ),
    .alu_op_o   ( alu_op   ),
    .op_a_sel_o ( op_a_sel ),
    .op_b_sel_o ( op_b_sel ),
    .imm_o      ( imm      ),
    .rd_we_o    ( rd_we    ),
    .illegal_o  ( illegal  )
  );

  id_operand_fetch i_operand_fetch (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .instr_i    ( instr_i    ),
    .wb_we_i    ( wb_we_i    ),
    .wb_waddr_i ( wb_waddr_i ),
    .wb_wdata_i ( wb_wdata_i ),
    .fw_we_i    ( fw_we_i    ),
    .fw_waddr_i ( fw_waddr_i ),
    .fw_wdata_i ( fw_wdata_i ),
    .rs1_data_o ( rs1_data   ),
    .rs2_data_o ( rs2_data   )
  );

  // Pipeline register toward EX
  id_ex_pipe i_id_ex_pipe (
    .clk             ( clk             ),
    .rst_n           ( rst_n           ),
    .instr_i         ( instr_i         ),
    .pc_i            ( pc_i            ),
    .instr_valid_i   ( instr_valid_i   ),
    .stall_ex_i      ( stall_ex_i      ),
    .alu_op_i        ( alu_op          ),
    .op_a_sel_i      ( op_a_sel        ),
    .op_b_sel_i      ( op_b_sel        ),
    .imm_i           ( imm             ),
    .rd_we_i         ( rd_we           ),
    .illegal_i       ( illegal         ),
    .rs1_data_i      ( rs1_data        ),
    .rs2_data_i      ( rs2_data        ),
    .ex_valid_o      ( ex_valid_o      ),
    .ex_alu_op_o     ( ex_alu_op_o     ),
    .ex_operand_a_o  ( ex_operand_a_o  ),
    .ex_operand_b_o  ( ex_operand_b_o  ),
    .ex_store_data_o ( ex_store_data_o ),
    .ex_rd_addr_o    ( ex_rd_addr_o    ),
    .ex_regfile_we_o ( ex_regfile_we_o ),
    .ex_illegal_o    ( ex_illegal_o    )
  );

endmodule

`default_nettype wire

//--- test/tb_id_stage.sv
`default_nettype none

`include "id_cfg.svh"

module tb_id_stage;

  //////////////////////////////////////////////////
  // Stimulus table layout
  //////////////////////////////////////////////////
  typedef struct packed {
    logic [`ID_XLEN-1:0] instr;
    logic [`ID_XLEN-1:0] pc;
    logic                valid;
    id_pkg::alu_op_e     alu;
    id_pkg::op_a_sel_e   a_sel;
    id_pkg::op_b_sel_e   b_sel;
    logic [`ID_XLEN-1:0] imm;
    logic                we;
    logic                illegal;
  } row_t;

  // Cycles allowed for ex_valid_o to show up
  localparam int MAX_WAIT = 8;
  // Row index of add x3, x0, x0
  localparam int X0_ROW = 13;

  logic                      clk;
  logic                      rst_n;
  logic [`ID_XLEN-1:0]       instr_i;
  logic [`ID_XLEN-1:0]       pc_i;
  logic                      instr_valid_i;
  logic                      stall_ex_i;
  logic                      wb_we_i;
  logic [`ID_REG_ADDR_W-1:0] wb_waddr_i;
  logic [`ID_XLEN-1:0]       wb_wdata_i;
  logic                      fw_we_i;
  logic [`ID_REG_ADDR_W-1:0] fw_waddr_i;
  logic [`ID_XLEN-1:0]       fw_wdata_i;

  logic                      ex_valid_o;
  id_pkg::alu_op_e           ex_alu_op_o;
  logic [`ID_XLEN-1:0]       ex_operand_a_o;
  logic [`ID_XLEN-1:0]       ex_operand_b_o;
  logic [`ID_XLEN-1:0]       ex_store_data_o;
  logic [`ID_REG_ADDR_W-1:0] ex_rd_addr_o;
  logic                      ex_regfile_we_o;
  logic                      ex_illegal_o;

  row_t                stim_table [$];
  // Mirror of the register file, x0 stays zero
  logic [`ID_XLEN-1:0] model_regs [`ID_NUM_REGS];

  id_stage i_dut (
    .clk             ( clk             ),
    .rst_n           ( rst_n           ),
    .instr_i         ( instr_i         ),
    .pc_i            ( pc_i            ),
    .instr_valid_i   ( instr_valid_i   ),
    .stall_ex_i      ( stall_ex_i      ),
    .wb_we_i         ( wb_we_i         ),
    .wb_waddr_i      ( wb_waddr_i      ),
    .wb_wdata_i      ( wb_wdata_i      ),
    .fw_we_i         ( fw_we_i         ),
    .fw_waddr_i      ( fw_waddr_i      ),
    .fw_wdata_i      ( fw_wdata_i      ),
    .ex_valid_o      ( ex_valid_o      ),
    .ex_alu_op_o     ( ex_alu_op_o     ),
    .ex_operand_a_o  ( ex_operand_a_o  ),
    .ex_operand_b_o  ( ex_operand_b_o  ),
    .ex_store_data_o ( ex_store_data_o ),
    .ex_rd_addr_o    ( ex_rd_addr_o    ),
    .ex_regfile_we_o ( ex_regfile_we_o ),
    .ex_illegal_o    ( ex_illegal_o    )
  );

  always #50 clk = ~clk;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////
  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp)
    begin
      $display("mismatch %s got 0x%0h expected 0x%0h", name, got, exp);
      $display(">>> FAIL");
      $fatal(1, "check failed");
    end
  endtask

  // Inputs change 10 units after the edge
  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic add_row(input logic [31:0] instr, input logic [31:0] pc, input logic valid,
                         input id_pkg::alu_op_e alu, input id_pkg::op_a_sel_e a_sel,
                         input id_pkg::op_b_sel_e b_sel, input logic [31:0] imm,
                         input logic we, input logic illegal);
    row_t r;
    r = '{instr, pc, valid, alu, a_sel, b_sel, imm, we, illegal};
    stim_table.push_back(r);
  endtask

  task automatic set_ports(input logic wb_we, input logic [4:0] wb_addr, input logic [31:0] wb_data,
                           input logic fw_we, input logic [4:0] fw_addr, input logic [31:0] fw_data);
    wb_we_i    = wb_we;
    wb_waddr_i = wb_addr;
    wb_wdata_i = wb_data;
    fw_we_i    = fw_we;
    fw_waddr_i = fw_addr;
    fw_wdata_i = fw_data;
  endtask

  // Source value seen this cycle: EX, then WB, then storage
  function automatic logic [`ID_XLEN-1:0] expect_reg(input logic [`ID_REG_ADDR_W-1:0] addr);
    logic [`ID_XLEN-1:0] val;
    if (addr == '0)
      val = '0;
    else if (fw_we_i && (fw_waddr_i == addr))
      val = fw_wdata_i;
    else if (wb_we_i && (wb_waddr_i == addr))
      val = wb_wdata_i;
    else
      val = model_regs[addr];
    return val;
  endfunction

  // Writes land at the next edge, EX applied last so it wins
  task automatic commit_writes();
    if (wb_we_i && (wb_waddr_i != '0))
      model_regs[wb_waddr_i] = wb_wdata_i;
    if (fw_we_i && (fw_waddr_i != '0))
      model_regs[fw_waddr_i] = fw_wdata_i;
  endtask

  function automatic logic [127:0] ex_snapshot();
    return {ex_valid_o, ex_alu_op_o, ex_operand_a_o, ex_operand_b_o, ex_store_data_o,
            ex_rd_addr_o, ex_regfile_we_o, ex_illegal_o};
  endfunction

  // Drive one row, wait for EX to see it, compare
  task automatic run_row(input row_t r);
    logic [`ID_XLEN-1:0] rs1_val;
    logic [`ID_XLEN-1:0] rs2_val;
    logic [`ID_XLEN-1:0] exp_a;
    logic [`ID_XLEN-1:0] exp_b;
    int                  cycles;
    instr_i       = r.instr;
    pc_i          = r.pc;
    instr_valid_i = r.valid;
    rs1_val = expect_reg(r.instr[`ID_RS1_LSB +: `ID_REG_ADDR_W]);
    rs2_val = expect_reg(r.instr[`ID_RS2_LSB +: `ID_REG_ADDR_W]);
    case (r.a_sel)
      id_pkg::OP_A_REG: exp_a = rs1_val;
      id_pkg::OP_A_PC:  exp_a = r.pc;
      default:          exp_a = '0;
    endcase
    case (r.b_sel)
      id_pkg::OP_B_REG: exp_b = rs2_val;
      id_pkg::OP_B_IMM: exp_b = r.imm;
      default:          exp_b = `ID_XLEN'(4);
    endcase
    commit_writes();
    cycles = 0;
    do
    begin
      next_cycle();
      cycles++;
    end
    while (r.valid && !ex_valid_o && (cycles < MAX_WAIT));
    if (r.valid && !ex_valid_o)
    begin
      $display("timeout waiting for ex_valid_o after a valid instruction");
      $display(">>> FAIL");
      $fatal(1, "timeout");
    end
    check("ex_valid_o", ex_valid_o, r.valid);
    check("ex latency in cycles", cycles, 1);
    // Empty slots never write or raise illegal
    check("ex_regfile_we_o", ex_regfile_we_o, r.we && r.valid);
    check("ex_illegal_o", ex_illegal_o, r.illegal && r.valid);
    if (r.valid && !r.illegal)
    begin
      check("ex_alu_op_o", ex_alu_op_o, r.alu);
      check("ex_operand_a_o", ex_operand_a_o, exp_a);
      check("ex_operand_b_o", ex_operand_b_o, exp_b);
      check("ex_store_data_o", ex_store_data_o, rs2_val);
      check("ex_rd_addr_o", ex_rd_addr_o, r.instr[`ID_RD_LSB +: `ID_REG_ADDR_W]);
    end
  endtask

  task automatic build_table();
    // add x3,x1,x2 / sub x4,x5,x6 / sra x7,x8,x9 / sltu x10,x11,x12
    add_row(32'h002081B3, 32'h100, 1, id_pkg::ALU_ADD, id_pkg::OP_A_REG, id_pkg::OP_B_REG, 0, 1, 0);
    add_row(32'h40628233, 32'h104, 1, id_pkg::ALU_SUB, id_pkg::OP_A_REG, id_pkg::OP_B_REG, 0, 1, 0);
    add_row(32'h409453B3, 32'h108, 1, id_pkg::ALU_SRA, id_pkg::OP_A_REG, id_pkg::OP_B_REG, 0, 1, 0);
    add_row(32'h00C5B533, 32'h10C, 1, id_pkg::ALU_SLTU, id_pkg::OP_A_REG, id_pkg::OP_B_REG, 0, 1, 0);
    // xori x13,x14,-1 / srai x15,x16,3
    add_row(32'hFFF74693, 32'h110, 1, id_pkg::ALU_XOR, id_pkg::OP_A_REG, id_pkg::OP_B_IMM,
            32'hFFFFFFFF, 1, 0);
    add_row(32'h40385793, 32'h114, 1, id_pkg::ALU_SRA, id_pkg::OP_A_REG, id_pkg::OP_B_IMM,
            32'h00000403, 1, 0);
    // lui x17 / auipc x18
    add_row(32'hABCDE8B7, 32'h118, 1, id_pkg::ALU_ADD, id_pkg::OP_A_ZERO, id_pkg::OP_B_IMM,
            32'hABCDE000, 1, 0);
    add_row(32'h12345917, 32'h1000, 1, id_pkg::ALU_ADD, id_pkg::OP_A_PC, id_pkg::OP_B_IMM,
            32'h12345000, 1, 0);
    // lw x19,-8(x20) / sw x22,-4(x21)
    add_row(32'hFF8A2983, 32'h120, 1, id_pkg::ALU_ADD, id_pkg::OP_A_REG, id_pkg::OP_B_IMM,
            32'hFFFFFFF8, 1, 0);
    add_row(32'hFF6AAE23, 32'h124, 1, id_pkg::ALU_ADD, id_pkg::OP_A_REG, id_pkg::OP_B_IMM,
            32'hFFFFFFFC, 0, 0);
    // jal x23 links pc + 4
    add_row(32'h00C00BEF, 32'h2000, 1, id_pkg::ALU_ADD, id_pkg::OP_A_PC, id_pkg::OP_B_PCINCR,
            0, 1, 0);
    // Opcode 7f is unsupported
    add_row(32'h000002FF, 32'h12C, 1, id_pkg::ALU_ADD, id_pkg::OP_A_REG, id_pkg::OP_B_REG, 0, 0, 1);
    // Empty slot, write gated off
    add_row(32'h002081B3, 32'h130, 0, id_pkg::ALU_ADD, id_pkg::OP_A_REG, id_pkg::OP_B_REG, 0, 1, 0);
    add_row(32'h000001B3, 32'h134, 1, id_pkg::ALU_ADD, id_pkg::OP_A_REG, id_pkg::OP_B_REG, 0, 1, 0);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial
  begin
    logic [127:0] held;
    clk           = 1'b0;
    rst_n         = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    instr_valid_i = 1'b0;
    stall_ex_i    = 1'b0;
    set_ports(0, 0, 0, 0, 0, 0);
    for (int i = 0; i < `ID_NUM_REGS; i++)
      model_regs[i] = '0;
    void'($urandom(32'h844b));
    build_table();

    repeat (5) @(posedge clk);
    #10;
    rst_n = 1'b1;

    // Reset state, then a read of untouched registers
    check("ex_valid_o", ex_valid_o, 0);
    check("ex_regfile_we_o", ex_regfile_we_o, 0);
    check("ex_illegal_o", ex_illegal_o, 0);
    run_row(stim_table[0]);

    // Random contents through write-back
    instr_valid_i = 1'b0;
    for (int i = 1; i < `ID_NUM_REGS; i++)
    begin
      set_ports(1, `ID_REG_ADDR_W'(i), $urandom, 0, 0, 0);
      commit_writes();
      next_cycle();
    end
    set_ports(0, 0, 0, 0, 0, 0);

    foreach (stim_table[i])
      run_row(stim_table[i]);

    // EX result forwarded to rs1
    set_ports(0, 0, 0, 1, 1, $urandom);
    run_row(stim_table[0]);
    // EX beats WB on rs2
    set_ports(1, 2, $urandom, 1, 2, $urandom);
    run_row(stim_table[0]);
    // Storage must now hold the EX value
    set_ports(0, 0, 0, 0, 0, 0);
    run_row(stim_table[0]);
    // x0 ignores both ports
    set_ports(1, 0, $urandom, 1, 0, $urandom);
    run_row(stim_table[X0_ROW]);
    set_ports(0, 0, 0, 0, 0, 0);

    ////////////////////////////////////////
    // Back-pressure from EX
    ////////////////////////////////////////
    run_row(stim_table[1]);
    held       = ex_snapshot();
    stall_ex_i = 1'b1;
    for (int i = 2; i < 5; i++)
    begin
      instr_i       = stim_table[i].instr;
      pc_i          = stim_table[i].pc;
      instr_valid_i = 1'b1;
      next_cycle();
      check("ex outputs while stalled", ex_snapshot(), held);
    end
    stall_ex_i = 1'b0;
    run_row(stim_table[4]);

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
rtl/id_pkg.sv
rtl/id_decoder.sv
rtl/id_operand_fetch.sv
rtl/id_ex_pipe.sv
rtl/id_stage.sv
test/tb_id_stage.sv
